//--- dv/tb_phy_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_phy_top;

   localparam int RESET_CYCLES = 16;
   localparam int BRINGUP_MAX  = 96;          // Six frames
   localparam int FAULT_MAX    = 64;
   localparam int DRAIN_MAX    = 200;
   localparam int HOLD_CYCLES  = 48;
   localparam int CYCLE_LIMIT  = 5000;        // Full run needs about 2000
   localparam int N_WORDS      = 300;
   localparam int N_GAP_WORDS  = 150;
   localparam int RX_READY     = 0;           // rx_tready_i always high
   localparam int RX_GAPS      = 1;           // Random gaps of 1 to 4 cycles
   localparam int RX_HOLD      = 2;           // rx_tready_i held low

   logic        aclk;
   logic        arst_n;
   logic [63:0] tx_tdata;
   logic        tx_tvalid;
   logic        tx_tready;
   logic [63:0] rx_tdata;
   logic        rx_tvalid;
   logic        rx_tready;
   logic [3:0]  status;
   logic [3:0]  ecode;
   logic        link_ready;
   logic        fault_fatal;
   logic [65:0] lane_tx;
   logic [65:0] lane_rx;

   logic        corrupt_data_req;             // Flip next data lane word
   logic        corrupt_faw_req;              // Flip next FAW
   logic        corrupt_done = 1'b0;
   logic        hit_now;

   logic [31:0] lfsr_q;
   logic [63:0] sb_queue [$];                 // Accepted TX words, oldest first
   logic [63:0] exp_word;
   logic        stall_q;
   logic [63:0] stall_data_q;
   int          checks        = 0;
   int          flow_errors   = 0;
   int          data_errors   = 0;
   int          words_checked = 0;
   int          cycle_cnt     = 0;

   phy_top u_dut (
      .aclk_i       (aclk),
      .arst_n_i     (arst_n),
      .tx_tdata_i   (tx_tdata),
      .tx_tvalid_i  (tx_tvalid),
      .tx_tready_o  (tx_tready),
      .rx_tdata_o   (rx_tdata),
      .rx_tvalid_o  (rx_tvalid),
      .rx_tready_i  (rx_tready),
      .status_o     (status),
      .ecode_o      (ecode),
      .link_ready_o (link_ready),
      .fault_fatal_o(fault_fatal),
      .lane_tx_o    (lane_tx),
      .lane_rx_i    (lane_rx)
   );

   initial aclk = 1'b0;
   always #50 aclk = ~aclk;                   // 100 ns period

   // ====================
   // Loopback with one-shot corruption
   // ====================

   assign hit_now = !corrupt_done &&
                    ((corrupt_data_req && lane_tx[65:64] == phy_pkg::HDR_DATA) ||
                     (corrupt_faw_req && lane_tx[65:64] == phy_pkg::HDR_CTRL &&
                      lane_tx[63:56] == phy_pkg::CTRL_FAW));
   assign lane_rx = lane_tx ^ (hit_now ? 66'd1 : 66'd0);   // Body bit 0

   always @(posedge aclk) begin
      if (!arst_n || (!corrupt_data_req && !corrupt_faw_req)) begin
         corrupt_done <= 1'b0;
      end else if (hit_now) begin
         corrupt_done <= 1'b1;                 // One word per request
      end
   end

   // ====================
   // Scoreboard and RX stall check
   // ====================

   always @(posedge aclk) begin
      if (!arst_n) begin
         sb_queue.delete();                    // Words in flight are lost on reset
         stall_q <= 1'b0;
      end else begin
         if (tx_tvalid && tx_tready) begin
            sb_queue.push_back(tx_tdata);
         end
         if (rx_tvalid && rx_tready) begin
            assert (sb_queue.size() > 0) else begin
               data_errors++;
               $display("Error at %0t: RX port delivered a word that was never sent", $time);
            end
            if (sb_queue.size() > 0) begin
               exp_word = sb_queue.pop_front();
               words_checked++;
               assert (rx_tdata === exp_word) else begin
                  data_errors++;
                  $display("FAIL %0t rx_tdata_o got=%0h exp=%0h", $time, rx_tdata, exp_word);
               end
            end
         end
         if (stall_q && rx_tvalid) begin        // Head must hold while stalled
            assert (rx_tdata === stall_data_q) else begin
               data_errors++;
               $display("FAIL %0t rx_tdata_o got=%0h exp=%0h", $time, rx_tdata, stall_data_q);
            end
         end
         stall_q      <= rx_tvalid && !rx_tready;
         stall_data_q <= rx_tdata;
      end
   end

   // ====================
   // Helpers
   // ====================

   // Fibonacci LFSR, taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic rand_bits(input int n, output logic [63:0] val);
      val = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_q = lfsr_step(lfsr_q);
         val    = {val[62:0], lfsr_q[0]};      // One step per bit
      end
   endtask

   task automatic expect_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
      checks++;
      assert (got === exp) else begin
         flow_errors++;
         $display("FAIL %0t %s got=%0h exp=%0h", $time, name, got, exp);
      end
   endtask

   task automatic expect_true(input string what, input logic cond);
      checks++;
      assert (cond) else begin
         flow_errors++;
         $display("Error at %0t: %s", $time, what);
      end
   endtask

   task automatic apply_reset();
      @(posedge aclk);
      arst_n    <= 1'b0;
      tx_tvalid <= 1'b0;
      rx_tready <= 1'b0;
      @(negedge aclk);
      expect_eq("link_ready_o", 64'(link_ready), 64'd0);
      expect_eq("fault_fatal_o", 64'(fault_fatal), 64'd0);
      expect_eq("tx_tready_o", 64'(tx_tready), 64'd0);
      expect_eq("rx_tvalid_o", 64'(rx_tvalid), 64'd0);
      expect_eq("status_o", 64'(status), 64'(phy_pkg::ST_RESET));
      repeat (RESET_CYCLES) @(posedge aclk);
      arst_n <= 1'b1;
   endtask

   task automatic bring_up();
      int cycles;
      cycles = 0;
      do begin
         @(negedge aclk);
         cycles++;
      end while (!link_ready && cycles < BRINGUP_MAX);
      expect_true("link_ready_o did not rise within 96 cycles of reset release", link_ready);
      expect_eq("status_o", 64'(status), 64'(phy_pkg::ST_READY));
      expect_eq("ecode_o", 64'(ecode), 64'(phy_pkg::EC_NONE));
   endtask

   // Random tvalid, TX beat held until accepted
   task automatic run_traffic(input int n_words, input int rx_mode);
      int          sent;
      int          gap;
      logic [63:0] r;
      sent = 0;
      gap  = 0;
      while (sent < n_words && !fault_fatal) begin
         @(posedge aclk);
         if (tx_tvalid && tx_tready) begin
            sent++;
         end
         if (sent >= n_words) begin
            tx_tvalid <= 1'b0;
         end else if (!tx_tvalid || tx_tready) begin
            rand_bits(1, r);
            tx_tvalid <= r[0];
            rand_bits(64, r);
            tx_tdata  <= r;
         end
         if (rx_mode == RX_READY) begin
            rx_tready <= 1'b1;
         end else if (rx_mode == RX_HOLD) begin
            rx_tready <= 1'b0;
         end else if (gap > 0) begin
            gap--;
            rx_tready <= 1'b0;
         end else begin
            rand_bits(3, r);
            if (r[2:0] == 3'd0) begin           // Gap starts, 1 to 4 cycles
               rand_bits(2, r);
               gap = int'(r[1:0]);
               rx_tready <= 1'b0;
            end else begin
               rx_tready <= 1'b1;
            end
         end
      end
   endtask

   task automatic wait_drain();
      int cycles;
      cycles = 0;
      do begin
         @(negedge aclk);
         cycles++;
      end while ((sb_queue.size() != 0 || rx_tvalid) && cycles < DRAIN_MAX);
      expect_true("RX port did not deliver every accepted word", sb_queue.size() == 0);
   endtask

   task automatic wait_fault();
      int cycles;
      cycles = 0;
      do begin
         @(negedge aclk);
         cycles++;
      end while (!fault_fatal && cycles < FAULT_MAX);
      expect_true("fault_fatal_o did not rise after the corrupted lane word", fault_fatal);
   endtask

   task automatic check_fault_outputs(input logic [3:0] code);
      expect_eq("ecode_o", 64'(ecode), 64'(code));
      expect_eq("fault_fatal_o", 64'(fault_fatal), 64'd1);
      expect_eq("status_o", 64'(status), 64'(phy_pkg::ST_FAULT));
      expect_eq("link_ready_o", 64'(link_ready), 64'd0);
      expect_eq("rx_tvalid_o", 64'(rx_tvalid), 64'd0);
      expect_eq("tx_tready_o", 64'(tx_tready), 64'd0);
   endtask

   // ====================
   // Test sequence
   // ====================

   initial begin
      arst_n           = 1'b0;
      tx_tdata         = '0;
      tx_tvalid        = 1'b0;
      rx_tready        = 1'b0;
      corrupt_data_req = 1'b0;
      corrupt_faw_req  = 1'b0;
      lfsr_q           = 32'hf1b2;

      apply_reset();                            // Reset state, then link training
      bring_up();

      run_traffic(N_WORDS, RX_READY);           // Integrity through framing and IDLE
      wait_drain();

      run_traffic(N_GAP_WORDS, RX_GAPS);        // Back-pressure on RX
      @(posedge aclk);
      rx_tready <= 1'b1;
      wait_drain();
      expect_eq("ecode_o", 64'(ecode), 64'(phy_pkg::EC_NONE));
      expect_eq("words delivered", 64'(words_checked), 64'(N_WORDS + N_GAP_WORDS));

      @(posedge aclk);
      corrupt_data_req <= 1'b1;                 // CRC must catch the flipped bit
      run_traffic(2, RX_HOLD);
      wait_fault();
      expect_true("no data lane word was corrupted", corrupt_done);
      check_fault_outputs(phy_pkg::EC_CRC);
      repeat (HOLD_CYCLES) begin               // Fault is sticky
         @(negedge aclk);
         check_fault_outputs(phy_pkg::EC_CRC);
      end
      @(posedge aclk);
      corrupt_data_req <= 1'b0;

      apply_reset();
      bring_up();
      @(posedge aclk);
      corrupt_faw_req <= 1'b1;                  // Lock loss at slot 0
      wait_fault();
      expect_true("no FAW lane word was corrupted", corrupt_done);
      check_fault_outputs(phy_pkg::EC_ALIGN_LOST);
      @(posedge aclk);
      corrupt_faw_req <= 1'b0;

      apply_reset();                            // Link recovers after reset
      bring_up();

      $display("Closing counts: checks=%0d flow_errors=%0d data_errors=%0d words_checked=%0d",
               checks, flow_errors, data_errors, words_checked);
      if (flow_errors == 0 && data_errors == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

   always @(posedge aclk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt == CYCLE_LIMIT) begin
         $display("Run stopped after %0d cycles because a test did not finish", CYCLE_LIMIT);
         $display("Closing counts: checks=%0d flow_errors=%0d data_errors=%0d words_checked=%0d",
                  checks, flow_errors, data_errors, words_checked);
         $display("Testbench failed");
         $finish;
      end
   end

endmodule

`default_nettype wire

//--- flist.f
+incdir+rtl
rtl/phy_pkg.sv
rtl/link_status_if.sv
rtl/sync_fifo.sv
rtl/tx_framer.sv
rtl/rx_deframer.sv
rtl/link_controller.sv
rtl/phy_top.sv
dv/tb_phy_top.sv

//--- rtl/link_controller.sv
`timescale 1ns/1ps
`default_nettype none

module link_controller (
   input  wire logic         aclk_i,
   input  wire logic         arst_n_i,
   link_status_if.controller link_if,
   input  wire logic         rx_overflow_i,    // RX FIFO dropped a word
   output logic              data_enable_o,    // Framer may send user data
   output logic              link_ready_o,
   output logic              fault_fatal_o,
   output phy_pkg::status_e  status_o,
   output phy_pkg::ecode_e   ecode_o           // First error, sticky
);

   phy_pkg::status_e state_q;
   phy_pkg::status_e state_d;
   phy_pkg::ecode_e  ecode_q;
   phy_pkg::ecode_e  ecode_d;
   logic             err_any;
   logic             take_fault;

   assign err_any    = link_if.crc_error || link_if.align_lost || rx_overflow_i;
   assign take_fault = err_any && (state_q != phy_pkg::ST_FAULT);

   // ====================
   // Bring-up FSM
   // ====================

   always_comb begin
      state_d = state_q;
      case (state_q)
         phy_pkg::ST_RESET: state_d = phy_pkg::ST_ALIGN;   // Framer already running
         phy_pkg::ST_ALIGN: begin
            if (link_if.rx_aligned) begin
               state_d = phy_pkg::ST_WAIT_REMOTE;
            end
         end
         phy_pkg::ST_WAIT_REMOTE: begin
            if (link_if.remote_ready) begin
               state_d = phy_pkg::ST_READY;
            end
         end
         phy_pkg::ST_READY: state_d = phy_pkg::ST_READY;
         default:           state_d = phy_pkg::ST_FAULT;   // Fault and illegal codes
      endcase
      if (take_fault) begin
         state_d = phy_pkg::ST_FAULT;
      end
   end

   // Several errors in one cycle, lowest code wins
   always_comb begin
      if (link_if.crc_error) begin
         ecode_d = phy_pkg::EC_CRC;
      end else if (link_if.align_lost) begin
         ecode_d = phy_pkg::EC_ALIGN_LOST;
      end else begin
         ecode_d = phy_pkg::EC_RX_OVERFLOW;
      end
   end

   always_ff @(posedge aclk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q <= phy_pkg::ST_RESET;
         ecode_q <= phy_pkg::EC_NONE;
      end else begin
         state_q <= state_d;
         if (take_fault) begin
            ecode_q <= ecode_d;                  // Only on entry to fault
         end
      end
   end

   // ====================
   // Enables from state
   // ====================

   assign link_if.rx_enable = (state_q == phy_pkg::ST_WAIT_REMOTE) ||
                              (state_q == phy_pkg::ST_READY);
   assign data_enable_o     = (state_q == phy_pkg::ST_READY);
   assign link_ready_o      = (state_q == phy_pkg::ST_READY);
   assign fault_fatal_o     = (state_q == phy_pkg::ST_FAULT);
   assign status_o          = state_q;
   assign ecode_o           = ecode_q;

endmodule

`default_nettype wire

//--- rtl/link_status_if.sv
`timescale 1ns/1ps
`default_nettype none

interface link_status_if;

   logic rx_aligned;    // Deframer locked to frame boundary
   logic remote_ready;  // Far end rx-ready, from last good CRC word
   logic crc_error;     // Single-cycle pulse
   logic align_lost;    // Single-cycle pulse
   logic rx_enable;     // Controller lets data through

   modport deframer (
      output rx_aligned, remote_ready, crc_error, align_lost,
      input  rx_enable
   );

   modport controller (
      input  rx_aligned, remote_ready, crc_error, align_lost,
      output rx_enable
   );

   // Local rx-ready goes out in every CRC word
   modport framer (
      input rx_enable
   );

endinterface

`default_nettype wire

//--- rtl/phy_cfg.svh
`ifndef PHY_CFG_SVH
`define PHY_CFG_SVH

// ====================
// Frame layout
// ====================

// Lane words per frame, FAW + payload + CRC
`define PHY_FRAME_LEN 16

// Data or IDLE slots between FAW and CRC
`define PHY_PAYLOAD_SLOTS 14

// ====================
// Buffering and alignment
// ====================

// FIFO address width, depth 2**AW
`define PHY_FIFO_AW 4

// Body bits 55..0 of the FAW control word
`define PHY_FAW_PATTERN 56'hA5_C3_96_3C_5A_0F_F0

// FAWs at one offset before the lane counts as aligned
`define PHY_ALIGN_FRAMES 2

`endif

//--- rtl/phy_pkg.sv
`default_nettype none

package phy_pkg;

   // ====================
   // Lane word format
   // ====================

   typedef logic [63:0] word_t;               // User payload word

   typedef struct packed {
      logic [1:0] hdr;                        // Sync header
      word_t      body;                       // Data or control body
   } lane_word_t;

   localparam logic [1:0] HDR_DATA = 2'b01;   // Body is user data
   localparam logic [1:0] HDR_CTRL = 2'b10;   // Body is a control word

   // Kind sits in body bits 63..56 of a control word
   typedef enum logic [7:0] {
      CTRL_FAW  = 8'h4B,                      // Frame alignment word
      CTRL_IDLE = 8'h1E,                      // Filler for empty slots
      CTRL_CRC  = 8'h2D                       // CRC plus rx-ready flag
   } ctrl_kind_e;

   // ====================
   // Status and errors
   // ====================

   typedef enum logic [3:0] {
      ST_RESET       = 4'd0,
      ST_ALIGN       = 4'd1,                  // Waiting for lane lock
      ST_WAIT_REMOTE = 4'd2,                  // Local RX on, far end pending
      ST_READY       = 4'd3,
      ST_FAULT       = 4'd4                   // Held until reset
   } status_e;

   typedef enum logic [3:0] {
      EC_NONE        = 4'd0,
      EC_CRC         = 4'd1,
      EC_ALIGN_LOST  = 4'd2,
      EC_RX_OVERFLOW = 4'd3
   } ecode_e;

   // CRC-16-CCITT, poly 0x1021, one 64-bit word MSB first
   function automatic logic [15:0] crc16_next(input logic [15:0] crc_in, input word_t data);
      logic [15:0] crc;
      logic        fb;
      crc = crc_in;
      for (int i = 63; i >= 0; i--) begin
         fb  = crc[15] ^ data[i];             // Feedback bit
         crc = {crc[14:0], 1'b0} ^ (fb ? 16'h1021 : 16'h0000);
      end
      return crc;
   endfunction

endpackage

`default_nettype wire

//--- rtl/phy_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "phy_cfg.svh"

module phy_top (
   input  wire logic        aclk_i,
   input  wire logic        arst_n_i,
   // ====================
   // User TX stream
   // ====================
   input  wire logic [63:0] tx_tdata_i,
   input  wire logic        tx_tvalid_i,
   output logic             tx_tready_o,      // FIFO space and link up
   // ====================
   // User RX stream
   // ====================
   output logic [63:0]      rx_tdata_o,       // RX FIFO head
   output logic             rx_tvalid_o,
   input  wire logic        rx_tready_i,
   // Status
   output logic [3:0]       status_o,
   output logic [3:0]       ecode_o,
   output logic             link_ready_o,
   output logic             fault_fatal_o,
   // Parallel lane
   output logic [65:0]      lane_tx_o,
   input  wire logic [65:0] lane_rx_i
);

   link_status_if link_if ();

   logic           data_enable;       // From controller, gates TX side
   logic           tx_fifo_full;
   logic           tx_fifo_empty;
   logic           tx_fifo_pop;
   phy_pkg::word_t tx_fifo_data;
   logic           rx_fifo_empty;
   logic           rx_fifo_overflow;
   logic           rx_pop;
   phy_pkg::word_t rx_data;
   logic           rx_data_valid;

   assign tx_tready_o = !tx_fifo_full && data_enable;
   assign rx_tvalid_o = !rx_fifo_empty && link_ready_o;
   assign rx_pop      = rx_tvalid_o && rx_tready_i;

   sync_fifo #(.AW(`PHY_FIFO_AW)) u_tx_fifo (
      .aclk_i    (aclk_i),
      .arst_n_i  (arst_n_i),
      .wr_en_i   (tx_tvalid_i && tx_tready_o),  // Handshake complete
      .wr_data_i (tx_tdata_i),
      .rd_en_i   (tx_fifo_pop),
      .rd_data_o (tx_fifo_data),
      .full_o    (tx_fifo_full),
      .empty_o   (tx_fifo_empty),
      .overflow_o()                              // Writes gated by ready
   );

   tx_framer u_tx_framer (
      .aclk_i       (aclk_i),
      .arst_n_i     (arst_n_i),
      .fifo_data_i  (tx_fifo_data),
      .fifo_empty_i (tx_fifo_empty),
      .data_enable_i(data_enable),
      .fifo_pop_o   (tx_fifo_pop),
      .lane_o       (lane_tx_o),
      .link_if      (link_if.framer)
   );

   rx_deframer u_rx_deframer (
      .aclk_i      (aclk_i),
      .arst_n_i    (arst_n_i),
      .lane_i      (lane_rx_i),
      .link_if     (link_if.deframer),
      .data_o      (rx_data),
      .data_valid_o(rx_data_valid)
   );

   sync_fifo #(.AW(`PHY_FIFO_AW)) u_rx_fifo (
      .aclk_i    (aclk_i),
      .arst_n_i  (arst_n_i),
      .wr_en_i   (rx_data_valid),
      .wr_data_i (rx_data),
      .rd_en_i   (rx_pop),
      .rd_data_o (rx_tdata_o),
      .full_o    (),                             // Overflow reported instead
      .empty_o   (rx_fifo_empty),
      .overflow_o(rx_fifo_overflow)
   );

   link_controller u_link_controller (
      .aclk_i       (aclk_i),
      .arst_n_i     (arst_n_i),
      .link_if      (link_if.controller),
      .rx_overflow_i(rx_fifo_overflow),
      .data_enable_o(data_enable),
      .link_ready_o (link_ready_o),
      .fault_fatal_o(fault_fatal_o),
      .status_o     (status_o),
      .ecode_o      (ecode_o)
   );

endmodule

`default_nettype wire

//--- rtl/rx_deframer.sv
`timescale 1ns/1ps
`default_nettype none
`include "phy_cfg.svh"

module rx_deframer (
   input  wire logic                aclk_i,
   input  wire logic                arst_n_i,
   input  wire phy_pkg::lane_word_t lane_i,       // Word from the lane
   link_status_if.deframer          link_if,
   output phy_pkg::word_t           data_o,       // To RX FIFO
   output logic                     data_valid_o
);

   localparam int SLOT_W = $clog2(`PHY_FRAME_LEN);
   localparam int CNT_W  = $clog2(`PHY_ALIGN_FRAMES + 1);
   localparam logic [SLOT_W-1:0] LAST_SLOT = SLOT_W'(`PHY_FRAME_LEN - 1);
   localparam logic [CNT_W-1:0]  LOCK_CNT  = CNT_W'(`PHY_ALIGN_FRAMES);
   localparam phy_pkg::word_t    FAW_BODY  = {phy_pkg::CTRL_FAW, `PHY_FAW_PATTERN};

   typedef enum logic [1:0] {
      S_HUNT,                                     // Any offset accepted
      S_CONFIRM,                                  // Counting FAWs at one offset
      S_LOCKED
   } align_e;

   align_e            state_q;
   logic [SLOT_W-1:0] slot_q;                     // Slot of the word on lane_i
   logic [CNT_W-1:0]  faw_cnt_q;
   logic [15:0]       crc_q;                      // CRC over data words this frame
   logic              remote_ready_q;
   logic              is_faw;
   logic              is_crc_word;
   logic              is_data;
   logic              at_faw_slot;
   logic              at_crc_slot;
   logic              locked;

   // ====================
   // Word decode
   // ====================

   assign is_faw      = (lane_i.hdr == phy_pkg::HDR_CTRL) && (lane_i.body == FAW_BODY);
   assign is_crc_word = (lane_i.hdr == phy_pkg::HDR_CTRL) &&
                        (lane_i.body[63:56] == phy_pkg::CTRL_CRC);
   assign is_data     = (lane_i.hdr == phy_pkg::HDR_DATA);
   assign at_faw_slot = (slot_q == '0);
   assign at_crc_slot = (slot_q == LAST_SLOT);
   assign locked      = (state_q == S_LOCKED);

   // Checks fire in the cycle the word is seen
   assign link_if.rx_aligned   = locked;
   assign link_if.remote_ready = remote_ready_q;
   assign link_if.align_lost   = locked && at_faw_slot && !is_faw;
   assign link_if.crc_error    = locked && at_crc_slot &&
                                 (!is_crc_word || (lane_i.body[15:0] != crc_q));

   // ====================
   // Alignment and CRC
   // ====================

   always_ff @(posedge aclk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q        <= S_HUNT;
         slot_q         <= '0;
         faw_cnt_q      <= '0;
         crc_q          <= 16'hFFFF;
         remote_ready_q <= 1'b0;
      end else if (state_q == S_HUNT) begin
         if (is_faw) begin                        // Candidate boundary
            state_q   <= S_CONFIRM;
            slot_q    <= SLOT_W'(1);
            faw_cnt_q <= CNT_W'(1);
            crc_q     <= 16'hFFFF;
         end
      end else begin
         slot_q <= at_crc_slot ? '0 : slot_q + 1'b1;
         if (at_faw_slot) begin
            crc_q <= 16'hFFFF;
            if (!is_faw) begin
               state_q <= S_HUNT;                 // Offset wrong or lock lost
            end else if (state_q == S_CONFIRM) begin
               faw_cnt_q <= faw_cnt_q + 1'b1;
               if (faw_cnt_q + 1'b1 == LOCK_CNT) begin
                  state_q <= S_LOCKED;
               end
            end
         end else if (at_crc_slot) begin
            if (locked && !link_if.crc_error) begin
               remote_ready_q <= lane_i.body[16];  // Far end flag, trusted after CRC
            end
         end else if (is_data) begin
            crc_q <= phy_pkg::crc16_next(crc_q, lane_i.body);
         end
      end
   end

   // ====================
   // Data extraction
   // ====================

   always_ff @(posedge aclk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         data_valid_o <= 1'b0;
      end else begin
         data_valid_o <= locked && link_if.rx_enable && is_data &&
                         !at_faw_slot && !at_crc_slot;
      end
   end

   always_ff @(posedge aclk_i) begin
      data_o <= lane_i.body;                      // Qualified by data_valid_o
   end

endmodule

`default_nettype wire

//--- rtl/sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
   parameter int AW = 4                               // Depth 2**AW
) (
   input  wire logic           aclk_i,
   input  wire logic           arst_n_i,
   input  wire logic           wr_en_i,
   input  wire phy_pkg::word_t wr_data_i,
   input  wire logic           rd_en_i,
   output phy_pkg::word_t      rd_data_o,             // Head of queue
   output logic                full_o,
   output logic                empty_o,
   output logic                overflow_o             // Write while full, dropped
);

   localparam int DEPTH = 2 ** AW;

   phy_pkg::word_t mem [DEPTH];                        // Storage, no reset
   logic [AW:0]    wr_ptr_q;                           // Extra MSB tells full from empty
   logic [AW:0]    rd_ptr_q;
   logic           do_wr;
   logic           do_rd;

   assign empty_o    = (wr_ptr_q == rd_ptr_q);
   assign full_o     = (wr_ptr_q[AW] != rd_ptr_q[AW]) &&
                       (wr_ptr_q[AW-1:0] == rd_ptr_q[AW-1:0]);
   assign overflow_o = wr_en_i && full_o;
   assign do_wr      = wr_en_i && !full_o;
   assign do_rd      = rd_en_i && !empty_o;
   assign rd_data_o  = mem[rd_ptr_q[AW-1:0]];

   always_ff @(posedge aclk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (do_rd) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
      end
   end

   always_ff @(posedge aclk_i) begin
      if (do_wr) begin
         mem[wr_ptr_q[AW-1:0]] <= wr_data_i;
      end
   end

endmodule

`default_nettype wire

//--- rtl/tx_framer.sv
`timescale 1ns/1ps
`default_nettype none
`include "phy_cfg.svh"

module tx_framer (
   input  wire logic           aclk_i,
   input  wire logic           arst_n_i,
   input  wire phy_pkg::word_t fifo_data_i,     // TX FIFO head
   input  wire logic           fifo_empty_i,
   input  wire logic           data_enable_i,   // User data allowed on the lane
   output logic                fifo_pop_o,
   output phy_pkg::lane_word_t lane_o,          // One word per cycle
   link_status_if.framer       link_if
);

   localparam int SLOT_W = $clog2(`PHY_FRAME_LEN);
   localparam logic [SLOT_W-1:0] LAST_SLOT = SLOT_W'(`PHY_FRAME_LEN - 1);
   localparam logic [SLOT_W-1:0] CRC_SLOT  = SLOT_W'(`PHY_PAYLOAD_SLOTS + 1);

   localparam phy_pkg::word_t FAW_BODY  = {phy_pkg::CTRL_FAW, `PHY_FAW_PATTERN};
   localparam phy_pkg::word_t IDLE_BODY = {phy_pkg::CTRL_IDLE, 56'h0};

   logic [SLOT_W-1:0]   slot_q;                  // Position in frame
   logic [15:0]         crc_q;                   // Running CRC over sent data
   phy_pkg::lane_word_t lane_q;
   logic                in_payload;
   phy_pkg::word_t      crc_body;

   assign in_payload = (slot_q != '0) && (slot_q != CRC_SLOT);
   assign fifo_pop_o = in_payload && data_enable_i && !fifo_empty_i;

   // Kind | zero pad | local rx-ready | CRC
   assign crc_body = {phy_pkg::CTRL_CRC, 39'h0, link_if.rx_enable, crc_q};

   // ====================
   // Slot sequencer
   // ====================

   always_ff @(posedge aclk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         slot_q <= '0;
         crc_q  <= 16'hFFFF;
         lane_q <= '{hdr: phy_pkg::HDR_CTRL, body: IDLE_BODY};  // Harmless until first FAW
      end else begin
         slot_q <= (slot_q == LAST_SLOT) ? '0 : slot_q + 1'b1;
         if (slot_q == '0) begin
            lane_q <= '{hdr: phy_pkg::HDR_CTRL, body: FAW_BODY};
         end else if (slot_q == CRC_SLOT) begin
            lane_q <= '{hdr: phy_pkg::HDR_CTRL, body: crc_body};
            crc_q  <= 16'hFFFF;                  // Restart for next frame
         end else if (fifo_pop_o) begin
            lane_q <= '{hdr: phy_pkg::HDR_DATA, body: fifo_data_i};
            crc_q  <= phy_pkg::crc16_next(crc_q, fifo_data_i);
         end else begin
            lane_q <= '{hdr: phy_pkg::HDR_CTRL, body: IDLE_BODY};  // Nothing to send
         end
      end
   end

   assign lane_o = lane_q;

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build and run the loopback testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f flist.f --top-module tb_phy_top \
   --Mdir obj_dir -o tb_phy_top_sim
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

./obj_dir/tb_phy_top_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Testbench failed" "$LOG"; then
   exit 1
fi
exit 0
